//--- core_sys_pkg.sv
//////////////////////////////////////////////////
// Core support shell definitions
// Widths, reset values, port structs and the
// scrambling key FSM encoding
//////////////////////////////////////////////////

package core_sys_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int unsigned NumRegs   = 32;
  localparam int unsigned RegAddrW  = 5;
  localparam int unsigned DataW     = 32;
  localparam int unsigned ScrKeyW   = 128;
  localparam int unsigned ScrNonceW = 64;

  typedef logic [RegAddrW-1:0]  reg_addr_t;
  typedef logic [DataW-1:0]     reg_data_t;
  typedef logic [ScrKeyW-1:0]   scr_key_t;
  typedef logic [ScrNonceW-1:0] scr_nonce_t;

  // Key material used until the first refresh
  localparam scr_key_t   ScrKeyDefault   = 128'h1d8a_6c03_f2b4_9e57_40c1_a8d6_35e9_7b2f;
  localparam scr_nonce_t ScrNonceDefault = 64'h9c4e_21b7_d05a_f368;

  //////////////////////////////////////////////////
  // Port structs
  //////////////////////////////////////////////////

  // Writeback from the core
  typedef struct packed {
    reg_addr_t waddr;
    reg_data_t wdata;
    logic      we;
    logic      fp_sel;
  } rf_wr_req_t;

  // Both read ports, each with its own bank select
  typedef struct packed {
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    logic      fp_sel_a;
    logic      fp_sel_b;
  } rf_rd_req_t;

  typedef struct packed {
    reg_data_t rdata_a;
    reg_data_t rdata_b;
  } rf_rd_data_t;

  // Key and nonce for the cache RAMs
  typedef struct packed {
    scr_key_t   key;
    scr_nonce_t nonce;
  } scr_cfg_t;

  //////////////////////////////////////////////////
  // Key refresh FSM
  //////////////////////////////////////////////////

  typedef enum logic [0:0] {
    KeyReady,
    KeyWait
  } key_state_e;

endpackage

//--- sleep_ctrl.sv
//////////////////////////////////////////////////
// Sleep control
// Registers core busy and reports sleep when no
// wake source is active
//////////////////////////////////////////////////

`timescale 1ns/1ps

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic core_sleep_o
);

  logic busy_q;
  logic clock_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  // Any wake source keeps the core clock running
  assign clock_en     = busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Sleep feeds the clock gate outside, so it must be clean
  a_sleep_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(core_sleep_o)
  );

endmodule

//--- register_bank.sv
//////////////////////////////////////////////////
// Register bank
// 32 words, one write port, two asynchronous read
// ports, optional hardwired zero in word 0
//////////////////////////////////////////////////

`timescale 1ns/1ps

module register_bank #(
  parameter bit HasZeroReg = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  we_i,
  input  core_sys_pkg::reg_addr_t waddr_i,
  input  core_sys_pkg::reg_data_t wdata_i,
  input  core_sys_pkg::reg_addr_t raddr_a_i,
  input  core_sys_pkg::reg_addr_t raddr_b_i,
  output core_sys_pkg::reg_data_t rdata_a_o,
  output core_sys_pkg::reg_data_t rdata_b_o
);

  import core_sys_pkg::*;

  reg_data_t          rf_words [NumRegs];
  logic [NumRegs-1:0] word_we;

  // One-hot write decode
  always_comb begin
    word_we          = '0;
    word_we[waddr_i] = we_i;
  end

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NumRegs; i++) begin : gen_words
    if (HasZeroReg && (i == 0)) begin : gen_zero
      // x0 ignores writes
      assign rf_words[i] = '0;
    end else begin : gen_flop
      reg_data_t word_q;

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          word_q <= '0;
        end else if (word_we[i]) begin
          word_q <= wdata_i;
        end
      end

      assign rf_words[i] = word_q;
    end
  end

  // No write bypass, a same-cycle read sees the old word
  assign rdata_a_o = rf_words[raddr_a_i];
  assign rdata_b_o = rf_words[raddr_b_i];

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  a_zero_reg_reads_zero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    HasZeroReg |-> ((raddr_a_i != '0) || (rdata_a_o == '0)) &&
                   ((raddr_b_i != '0) || (rdata_b_o == '0))
  );

endmodule

//--- rf_router.sv
//////////////////////////////////////////////////
// Register file router
// Steers writeback to the integer or FP bank and
// selects the source bank of each read port
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rf_router (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  core_sys_pkg::rf_wr_req_t  wr_i,
  input  core_sys_pkg::rf_rd_req_t  rd_i,
  output core_sys_pkg::rf_rd_data_t rd_o
);

  import core_sys_pkg::*;

  logic      int_we;
  logic      fp_we;
  reg_data_t int_rdata_a;
  reg_data_t int_rdata_b;
  reg_data_t fp_rdata_a;
  reg_data_t fp_rdata_b;

  // Writeback lands in exactly one bank
  assign int_we = wr_i.we & ~wr_i.fp_sel;
  assign fp_we  = wr_i.we &  wr_i.fp_sel;

  //////////////////////////////////////////////////
  // Banks
  //////////////////////////////////////////////////

  register_bank #(
    .HasZeroReg(1'b1)
  ) u_int_bank (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .we_i     (int_we),
    .waddr_i  (wr_i.waddr),
    .wdata_i  (wr_i.wdata),
    .raddr_a_i(rd_i.raddr_a),
    .raddr_b_i(rd_i.raddr_b),
    .rdata_a_o(int_rdata_a),
    .rdata_b_o(int_rdata_b)
  );

  // All FP registers are writable
  register_bank #(
    .HasZeroReg(1'b0)
  ) u_fp_bank (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .we_i     (fp_we),
    .waddr_i  (wr_i.waddr),
    .wdata_i  (wr_i.wdata),
    .raddr_a_i(rd_i.raddr_a),
    .raddr_b_i(rd_i.raddr_b),
    .rdata_a_o(fp_rdata_a),
    .rdata_b_o(fp_rdata_b)
  );

  // Per-port read select
  assign rd_o.rdata_a = rd_i.fp_sel_a ? fp_rdata_a : int_rdata_a;
  assign rd_o.rdata_b = rd_i.fp_sel_b ? fp_rdata_b : int_rdata_b;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  a_one_bank_we: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(int_we && fp_we)
  );

endmodule

//--- key_manager.sv
//////////////////////////////////////////////////
// Scrambling key manager
// Holds key and nonce for the cache RAMs and runs
// the request/valid refresh after an invalidate
//////////////////////////////////////////////////

`timescale 1ns/1ps

module key_manager (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     icache_inval_i,
  input  logic                     scramble_key_valid_i,
  input  core_sys_pkg::scr_key_t   scramble_key_i,
  input  core_sys_pkg::scr_nonce_t scramble_nonce_i,
  output logic                     scramble_req_o,
  output logic                     key_valid_o,
  output core_sys_pkg::scr_cfg_t   scr_cfg_o
);

  import core_sys_pkg::*;

  key_state_e state_q;
  key_state_e state_d;
  scr_cfg_t   cfg_q;

  //////////////////////////////////////////////////
  // Refresh FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      KeyReady: begin
        if (icache_inval_i) begin
          state_d = KeyWait;
        end
      end
      KeyWait: begin
        // Request stays up until the key source answers
        if (scramble_key_valid_i) begin
          state_d = KeyReady;
        end
      end
      default: state_d = KeyReady;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= KeyReady;
    end else begin
      state_q <= state_d;
    end
  end

  assign scramble_req_o = (state_q == KeyWait);
  assign key_valid_o    = (state_q == KeyReady);

  //////////////////////////////////////////////////
  // Key storage
  //////////////////////////////////////////////////

  // Any strobe updates the key, even outside a request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q.key   <= ScrKeyDefault;
      cfg_q.nonce <= ScrNonceDefault;
    end else if (scramble_key_valid_i) begin
      cfg_q.key   <= scramble_key_i;
      cfg_q.nonce <= scramble_nonce_i;
    end
  end

  assign scr_cfg_o = cfg_q;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  a_req_valid_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(scramble_req_o && key_valid_o)
  );

endmodule

//--- core_sys_top.sv
//////////////////////////////////////////////////
// Core support shell top
// Sleep reporting, integer and FP register files
// and scrambling key management
//////////////////////////////////////////////////

`timescale 1ns/1ps

module core_sys_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Register file access from the core
  input  core_sys_pkg::rf_wr_req_t  rf_wr_i,
  input  core_sys_pkg::rf_rd_req_t  rf_rd_i,
  output core_sys_pkg::rf_rd_data_t rf_rd_o,

  // Wake sources
  input  logic                      core_busy_i,
  input  logic                      debug_req_i,
  input  logic                      irq_pending_i,
  input  logic                      irq_nm_i,
  output logic                      core_sleep_o,

  // Key refresh
  input  logic                      icache_inval_i,
  input  logic                      scramble_key_valid_i,
  input  core_sys_pkg::scr_key_t    scramble_key_i,
  input  core_sys_pkg::scr_nonce_t  scramble_nonce_i,
  output logic                      scramble_req_o,
  output logic                      scr_key_valid_o,
  output core_sys_pkg::scr_cfg_t    scr_cfg_o
);

  //////////////////////////////////////////////////
  // Sleep
  //////////////////////////////////////////////////

  sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .core_sleep_o (core_sleep_o)
  );

  //////////////////////////////////////////////////
  // Register files
  //////////////////////////////////////////////////

  rf_router u_rf_router (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .wr_i  (rf_wr_i),
    .rd_i  (rf_rd_i),
    .rd_o  (rf_rd_o)
  );

  //////////////////////////////////////////////////
  // Scrambling key
  //////////////////////////////////////////////////

  // Key and valid go to the cache RAMs outside
  key_manager u_key_manager (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .key_valid_o         (scr_key_valid_o),
    .scr_cfg_o           (scr_cfg_o)
  );

endmodule

//--- tb_core_sys.sv
//////////////////////////////////////////////////
// Core support shell testbench
// Reference model of both register banks, sleep
// and key refresh, checked by assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_core_sys;

  import core_sys_pkg::*;

  localparam int KeyTimeout = 16;

  logic        clk_i;
  logic        rst_ni;
  rf_wr_req_t  rf_wr_i;
  rf_rd_req_t  rf_rd_i;
  rf_rd_data_t rf_rd_o;
  logic        core_busy_i;
  logic        debug_req_i;
  logic        irq_pending_i;
  logic        irq_nm_i;
  logic        core_sleep_o;
  logic        icache_inval_i;
  logic        scramble_key_valid_i;
  scr_key_t    scramble_key_i;
  scr_nonce_t  scramble_nonce_i;
  logic        scramble_req_o;
  logic        scr_key_valid_o;
  scr_cfg_t    scr_cfg_o;

  // Reference model
  reg_data_t  int_model [NumRegs];
  reg_data_t  fp_model [NumRegs];
  logic       busy_model;
  logic       exp_wait;
  scr_cfg_t   exp_cfg;
  logic       exp_sleep;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;
  int     test_start_errors;
  bit     timed_out;

  core_sys_top u_core_sys_top (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .rf_wr_i             (rf_wr_i),
    .rf_rd_i             (rf_rd_i),
    .rf_rd_o             (rf_rd_o),
    .core_busy_i         (core_busy_i),
    .debug_req_i         (debug_req_i),
    .irq_pending_i       (irq_pending_i),
    .irq_nm_i            (irq_nm_i),
    .core_sleep_o        (core_sleep_o),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .scr_key_valid_o     (scr_key_valid_o),
    .scr_cfg_o           (scr_cfg_o)
  );

  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Model update
  //////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin : model_update
    int i;
    if (!rst_ni) begin
      for (i = 0; i < NumRegs; i++) begin
        int_model[i] <= '0;
        fp_model[i]  <= '0;
      end
      busy_model <= 1'b0;
      exp_wait   <= 1'b0;
      exp_cfg    <= '{key: ScrKeyDefault, nonce: ScrNonceDefault};
    end else begin
      busy_model <= core_busy_i;
      if (rf_wr_i.we) begin
        if (rf_wr_i.fp_sel) begin
          fp_model[rf_wr_i.waddr] <= rf_wr_i.wdata;
        end else if (rf_wr_i.waddr != '0) begin
          int_model[rf_wr_i.waddr] <= rf_wr_i.wdata;
        end
      end
      if (!exp_wait && icache_inval_i) begin
        exp_wait <= 1'b1;
      end else if (exp_wait && scramble_key_valid_i) begin
        exp_wait <= 1'b0;
      end
      if (scramble_key_valid_i) begin
        exp_cfg <= '{key: scramble_key_i, nonce: scramble_nonce_i};
      end
    end
  end

  assign exp_sleep = !(busy_model || debug_req_i || irq_pending_i || irq_nm_i);

  a_sleep_rule: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o == exp_sleep
  ) else begin
    errors++;
    $display("Error at %0t: core_sleep_o got %b expected %b", $time,
             $sampled(core_sleep_o), $sampled(exp_sleep));
  end

  // Key handshake outputs follow the model every cycle
  a_key_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    scramble_req_o == exp_wait
  ) else begin
    errors++;
    $display("Error at %0t: scramble_req_o got %b expected %b", $time,
             $sampled(scramble_req_o), $sampled(exp_wait));
  end

  a_key_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    scr_key_valid_o == !exp_wait
  ) else begin
    errors++;
    $display("Error at %0t: scr_key_valid_o got %b expected %b", $time,
             $sampled(scr_key_valid_o), !$sampled(exp_wait));
  end

  //////////////////////////////////////////////////
  // Checks and helpers
  //////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input reg_data_t got, input reg_data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cfg(input string name, input scr_cfg_t got, input scr_cfg_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic reg_data_t model_read(input logic fp, input reg_addr_t addr);
    if (fp) begin
      return fp_model[addr];
    end
    if (addr == '0) begin
      return '0;
    end
    return int_model[addr];
  endfunction

  task automatic check_reads();
    check_word("rf_rd_o.rdata_a", rf_rd_o.rdata_a,
               model_read(rf_rd_i.fp_sel_a, rf_rd_i.raddr_a));
    check_word("rf_rd_o.rdata_b", rf_rd_o.rdata_b,
               model_read(rf_rd_i.fp_sel_b, rf_rd_i.raddr_b));
  endtask

  task automatic check_key_state();
    check_bit("scramble_req_o", scramble_req_o, exp_wait);
    check_bit("scr_key_valid_o", scr_key_valid_o, !exp_wait);
    check_cfg("scr_cfg_o", scr_cfg_o, exp_cfg);
  endtask

  // Inputs change a little after the rising edge
  task automatic next_drive();
    @(posedge clk_i);
    #10;
  endtask

  task automatic start_test();
    test_start_errors = errors;
    tests_run++;
  endtask

  task automatic finish_test(input string name);
    if (errors != test_start_errors || timed_out) begin
      tests_failed++;
      $display("[%0t] test %s: FAILED with %0d errors", $time, name,
               errors - test_start_errors);
    end else begin
      $display("[%0t] test %s: ok", $time, name);
    end
  endtask

  task automatic drive_write(input logic fp, input reg_addr_t addr, input reg_data_t data);
    rf_wr_i.we     = 1'b1;
    rf_wr_i.fp_sel = fp;
    rf_wr_i.waddr  = addr;
    rf_wr_i.wdata  = data;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    int a;
    start_test();
    for (a = 0; a < NumRegs; a++) begin
      next_drive();
      rf_rd_i = '{raddr_a: reg_addr_t'(a), raddr_b: reg_addr_t'(a), fp_sel_a: 1'b0,
                  fp_sel_b: 1'b1};
      @(negedge clk_i);
      check_reads();
      check_word("rf_rd_o.rdata_a", rf_rd_o.rdata_a, '0);
      check_word("rf_rd_o.rdata_b", rf_rd_o.rdata_b, '0);
    end
    check_key_state();
    check_cfg("scr_cfg_o", scr_cfg_o, '{key: ScrKeyDefault, nonce: ScrNonceDefault});
    finish_test("reset_state");
  endtask

  task automatic test_int_bank();
    int        n;
    reg_addr_t addr;
    start_test();
    for (n = 0; n < 24; n++) begin
      addr = (n % 5 == 0) ? reg_addr_t'(0) : reg_addr_t'($random(seed));
      next_drive();
      drive_write(1'b0, addr, $random(seed));
      rf_rd_i = '{raddr_a: addr, raddr_b: reg_addr_t'($random(seed)), fp_sel_a: 1'b0,
                  fp_sel_b: 1'b0};
      // Same cycle read still returns the old word
      @(negedge clk_i);
      check_reads();
      next_drive();
      rf_wr_i.we = 1'b0;
      rf_rd_i.raddr_b = addr;
      @(negedge clk_i);
      check_reads();
      if (addr == '0) begin
        check_word("rf_rd_o.rdata_a", rf_rd_o.rdata_a, '0);
      end
    end
    finish_test("int_bank");
  endtask

  task automatic test_bank_separation();
    int        n;
    reg_addr_t addr;
    reg_data_t data;
    start_test();
    for (n = 0; n < 8; n++) begin
      addr = (n == 0) ? reg_addr_t'(0) : reg_addr_t'($random(seed));
      data = $random(seed);
      next_drive();
      drive_write(1'b0, addr, data);
      next_drive();
      drive_write(1'b1, addr, ~data);
      next_drive();
      rf_wr_i.we = 1'b0;
      rf_rd_i = '{raddr_a: addr, raddr_b: addr, fp_sel_a: 1'b0, fp_sel_b: 1'b1};
      @(negedge clk_i);
      check_reads();
      check_word("rf_rd_o.rdata_b", rf_rd_o.rdata_b, ~data);
      next_drive();
      rf_rd_i.fp_sel_a = 1'b1;
      rf_rd_i.fp_sel_b = 1'b0;
      @(negedge clk_i);
      check_reads();
    end
    finish_test("bank_separation");
  endtask

  task automatic test_sleep();
    int          n;
    logic [31:0] r;
    start_test();
    for (n = 0; n < 48; n++) begin
      next_drive();
      r = $random(seed);
      core_busy_i   = r[0];
      debug_req_i   = r[1] & r[2];
      irq_pending_i = r[3] & r[4];
      irq_nm_i      = r[5] & r[6] & r[7];
      @(negedge clk_i);
      check_bit("core_sleep_o", core_sleep_o, exp_sleep);
    end
    next_drive();
    {core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = '0;
    finish_test("sleep");
  endtask

  task automatic test_key_refresh();
    int         round;
    int         delay;
    int         cnt;
    scr_key_t   key;
    scr_nonce_t nonce;
    start_test();
    for (round = 0; round < 4; round++) begin
      next_drive();
      icache_inval_i = 1'b1;
      next_drive();
      icache_inval_i = 1'b0;
      @(negedge clk_i);
      check_key_state();
      check_bit("scramble_req_o", scramble_req_o, 1'b1);
      delay = 1 + ($random(seed) & 3);
      repeat (delay) next_drive();
      key   = {$random(seed), $random(seed), $random(seed), $random(seed)};
      nonce = {$random(seed), $random(seed)};
      scramble_key_valid_i = 1'b1;
      scramble_key_i       = key;
      scramble_nonce_i     = nonce;
      next_drive();
      scramble_key_valid_i = 1'b0;
      cnt = 0;
      @(negedge clk_i);
      while (scr_key_valid_o !== 1'b1 && cnt < KeyTimeout) begin
        @(negedge clk_i);
        cnt++;
      end
      if (scr_key_valid_o !== 1'b1) begin
        timed_out = 1'b1;
        $display("Timeout: scr_key_valid_o did not rise within %0d cycles", KeyTimeout);
        finish_test("key_refresh");
        return;
      end
      check_key_state();
      check_cfg("scr_cfg_o", scr_cfg_o, '{key: key, nonce: nonce});
    end
    finish_test("key_refresh");
  endtask

  initial begin
    clk_i                = 1'b0;
    rst_ni               = 1'b0;
    rf_wr_i              = '0;
    rf_rd_i              = '0;
    core_busy_i          = 1'b0;
    debug_req_i          = 1'b0;
    irq_pending_i        = 1'b0;
    irq_nm_i             = 1'b0;
    icache_inval_i       = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i       = '0;
    scramble_nonce_i     = '0;
    seed                 = 32'h3722_bc4d;
    errors               = 0;
    checks               = 0;
    tests_run            = 0;
    tests_failed         = 0;
    timed_out            = 1'b0;
    repeat (4) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    test_reset_state();
    test_int_bank();
    test_bank_separation();
    test_sleep();
    test_key_refresh();

    $display("Tests run %0d, passed %0d, failed %0d, checks %0d, errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sim.f
core_sys_pkg.sv
sleep_ctrl.sv
register_bank.sv
rf_router.sv
key_manager.sv
core_sys_top.sv
tb_core_sys.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core support shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --assert -f sim.f --top-module tb_core_sys \
    --Mdir obj_dir -o tb_core_sys; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_core_sys 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation completed successfully" <<< "$sim_out"; then
  exit 0
fi
exit 1
